// ==== source/sd_spi_pkg.sv ====
// ======================================================================
// Shared types, enums and SPI-mode protocol constants of the SD card PHY.
// Modules import it by wildcard and use scoped names in their port lists.
// ======================================================================
package sd_spi_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] blk_addr_t;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} sd_op_e;

	typedef struct packed {
		sd_op_e    op;
		blk_addr_t addr;
	} sd_req_t;

	typedef enum logic [5:0] {
		CMD_GO_IDLE      = 6'd0,
		CMD_READ_SINGLE  = 6'd17,
		CMD_WRITE_SINGLE = 6'd24
	} sd_cmd_e;

	typedef enum logic [3:0] {
		POWER_UP, SEND_CMD, WAIT_R1, IDLE,
		WAIT_TOKEN, READ_DATA, READ_CRC,
		WRITE_DATA, WRITE_CRC, WAIT_DRESP, WAIT_BUSY,
		FAULT
	} phy_state_e;

	// bytes on the wire.
	localparam byte_t      IDLE_BYTE      = 8'hFF;
	localparam byte_t      START_TOKEN    = 8'hFE;
	localparam byte_t      R1_IDLE        = 8'h01;
	// status field of the data-response token.
	localparam logic [2:0] DRESP_ACCEPTED = 3'b010;

	localparam int CMD_FRAME_BYTES = 6;
	localparam int POWER_UP_BYTES  = 10;
	localparam int R1_POLL_LIMIT   = 8;

endpackage

// ==== source/spi_byte_master.sv ====
// ======================================================================
// Mode-0 SPI shifter; a start strobe exchanges one byte, MSB first,
// with SCLK_DIV system clocks per SPI half-period.
// ======================================================================
`timescale 1ns/100ps

module spi_byte_master #(
	parameter int SCLK_DIV = 4
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               start_i,
	input  sd_spi_pkg::byte_t  tx_byte_i,
	output sd_spi_pkg::byte_t  rx_byte_o,
	output logic               done_o,
	output logic               sclk_o,
	output logic               mosi_o,
	input  logic               miso_i
);
	import sd_spi_pkg::*;

	localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

	logic             busy;
	logic [DIV_W-1:0] div_cnt;
	logic [3:0]       edge_cnt;
	logic             sclk_q;
	byte_t            tx_sh;
	byte_t            rx_sh;
	logic             half_end;

	assign half_end = busy && (div_cnt == DIV_W'(SCLK_DIV - 1));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy     <= 1'b0;
			div_cnt  <= '0;
			edge_cnt <= '0;
			sclk_q   <= 1'b0;
			done_o   <= 1'b0;
			tx_sh    <= IDLE_BYTE;
		end else begin
			done_o <= 1'b0;
			if (start_i && !busy) begin
				busy     <= 1'b1;
				div_cnt  <= '0;
				edge_cnt <= '0;
				tx_sh    <= tx_byte_i;
			end else if (half_end) begin
				div_cnt  <= '0;
				sclk_q   <= ~sclk_q;
				edge_cnt <= edge_cnt + 4'd1;
				// next bit goes out on the falling edge.
				if (sclk_q)
					tx_sh <= {tx_sh[6:0], 1'b1};
				if (edge_cnt == 4'd15) begin
					busy   <= 1'b0;
					done_o <= 1'b1;
				end
			end else if (busy) begin
				div_cnt <= div_cnt + DIV_W'(1);
			end
		end
	end

	// sample on the rising edge.
	always_ff @(posedge clk_i) begin
		if (half_end && !sclk_q)
			rx_sh <= {rx_sh[6:0], miso_i};
	end

	assign sclk_o    = sclk_q;
	assign mosi_o    = tx_sh[7];
	assign rx_byte_o = rx_sh;

endmodule

// ==== source/sd_crc_unit.sv ====
// ======================================================================
// CRC7 and CRC16-CCITT accumulators, fed one byte per strobe and
// shifted one bit per clock; clear restarts both sums.
// ======================================================================
`timescale 1ns/100ps

module sd_crc_unit (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              clear_i,
	input  sd_spi_pkg::byte_t byte_i,
	input  logic              strobe_i,
	output logic [6:0]        crc7_o,
	output logic [15:0]       crc16_o
);
	import sd_spi_pkg::*;

	byte_t      sh;
	logic [3:0] bits_left;
	logic       crc7_in;
	logic       crc16_in;

	assign crc7_in  = sh[7] ^ crc7_o[6];
	assign crc16_in = sh[7] ^ crc16_o[15];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bits_left <= '0;
			crc7_o    <= '0;
			crc16_o   <= '0;
		end else begin
			if (bits_left != 4'd0) begin
				// x^7 + x^3 + 1.
				crc7_o    <= {crc7_o[5:3], crc7_o[2] ^ crc7_in, crc7_o[1:0], crc7_in};
				// x^16 + x^12 + x^5 + 1.
				crc16_o   <= {crc16_o[14:12], crc16_o[11] ^ crc16_in, crc16_o[10:5],
				              crc16_o[4] ^ crc16_in, crc16_o[3:0], crc16_in};
				bits_left <= bits_left - 4'd1;
			end
			if (clear_i) begin
				crc7_o  <= '0;
				crc16_o <= '0;
			end
			if (strobe_i)
				bits_left <= 4'd8;
		end
	end

	always_ff @(posedge clk_i) begin
		if (strobe_i)
			sh <= byte_i;
		else if (bits_left != 4'd0)
			sh <= {sh[6:0], 1'b0};
	end

endmodule

// ==== source/sd_req_regs.sv ====
// ======================================================================
// Request register; holds the accepted request and addressing mode and
// serves command-frame bytes 0 to 4 to the sequencer by index.
// ======================================================================
`timescale 1ns/100ps

module sd_req_regs #(
	parameter int BLOCK_BYTES = 512
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                req_valid_i,
	input  sd_spi_pkg::sd_req_t req_i,
	input  logic                accept_i,
	input  logic                high_capacity_i,
	input  logic                go_idle_i,
	input  logic [2:0]          frame_idx_i,
	output sd_spi_pkg::byte_t   frame_byte_o,
	output logic                is_write_o
);
	import sd_spi_pkg::*;

	sd_req_t   req_q;
	logic      hc_q;
	sd_cmd_e   cmd;
	blk_addr_t arg;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q.op <= OP_READ;
			hc_q     <= 1'b0;
		end else if (accept_i && req_valid_i) begin
			req_q.op <= req_i.op;
			hc_q     <= high_capacity_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept_i && req_valid_i)
			req_q.addr <= req_i.addr;
	end

	assign is_write_o = (req_q.op == OP_WRITE);

	always_comb begin
		if (go_idle_i) begin
			cmd = CMD_GO_IDLE;
			arg = '0;
		end else begin
			cmd = is_write_o ? CMD_WRITE_SINGLE : CMD_READ_SINGLE;
			// standard capacity cards take a byte address.
			arg = hc_q ? req_q.addr : req_q.addr * blk_addr_t'(BLOCK_BYTES);
		end
		case (frame_idx_i)
			3'd0:    frame_byte_o = {2'b01, cmd};
			3'd1:    frame_byte_o = arg[31:24];
			3'd2:    frame_byte_o = arg[23:16];
			3'd3:    frame_byte_o = arg[15:8];
			3'd4:    frame_byte_o = arg[7:0];
			default: frame_byte_o = IDLE_BYTE;
		endcase
	end

endmodule

// ==== source/sd_spi_sequencer.sv ====
// ======================================================================
// Protocol FSM of the PHY; runs power-up and CMD0, then single-block
// reads and writes with their tokens, CRC16 and busy wait.
// ======================================================================
`timescale 1ns/100ps

module sd_spi_sequencer #(
	parameter int BLOCK_BYTES      = 512,
	parameter int TOKEN_POLL_LIMIT = 1024
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              req_valid_i,
	output logic              accept_o,
	output logic              ready_o,
	output logic              go_idle_o,
	output logic [2:0]        frame_idx_o,
	input  sd_spi_pkg::byte_t frame_byte_i,
	input  logic              is_write_i,
	output logic              spi_start_o,
	output sd_spi_pkg::byte_t spi_tx_o,
	input  logic              spi_done_i,
	input  sd_spi_pkg::byte_t spi_rx_i,
	output logic              crc_clear_o,
	output sd_spi_pkg::byte_t crc_byte_o,
	output logic              crc_strobe_o,
	input  logic [6:0]        crc7_i,
	input  logic [15:0]       crc16_i,
	input  sd_spi_pkg::byte_t wr_data_i,
	output logic              wr_take_o,
	output sd_spi_pkg::byte_t rd_data_o,
	output logic              rd_valid_o,
	output logic              done_o,
	output logic              err_o,
	output logic              cs_o
);
	import sd_spi_pkg::*;

	localparam int CNT_MAX0 = (BLOCK_BYTES > TOKEN_POLL_LIMIT) ? BLOCK_BYTES : TOKEN_POLL_LIMIT;
	localparam int CNT_MAX  = (CNT_MAX0 > POWER_UP_BYTES) ? CNT_MAX0 : POWER_UP_BYTES;
	localparam int CNT_W    = $clog2(CNT_MAX + 1);

	phy_state_e       state;
	logic [CNT_W-1:0] cnt;
	logic             spi_busy;
	logic             in_init;
	logic             tok_sent;
	logic             launch;
	logic             rx_done;
	byte_t            tx_next;
	logic             strobe_tx;
	logic             take_tx;

	assign ready_o     = (state == IDLE);
	assign accept_o    = ready_o;
	assign go_idle_o   = in_init;
	assign frame_idx_o = cnt[2:0];
	assign launch      = !spi_busy && (state != IDLE) && (state != FAULT);
	assign rx_done     = spi_busy && spi_done_i;

	// byte to send next, and whether it enters the CRC.
	always_comb begin
		tx_next   = IDLE_BYTE;
		strobe_tx = 1'b0;
		take_tx   = 1'b0;
		case (state)
			SEND_CMD: begin
				if (cnt == CNT_W'(CMD_FRAME_BYTES - 1)) begin
					tx_next = {crc7_i, 1'b1};
				end else begin
					tx_next   = frame_byte_i;
					strobe_tx = 1'b1;
				end
			end
			WRITE_DATA: begin
				tx_next   = tok_sent ? wr_data_i : START_TOKEN;
				strobe_tx = tok_sent;
				take_tx   = tok_sent;
			end
			WRITE_CRC: tx_next = (cnt == '0) ? crc16_i[15:8] : crc16_i[7:0];
			default:   tx_next = IDLE_BYTE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state        <= POWER_UP;
			cnt          <= '0;
			spi_busy     <= 1'b0;
			in_init      <= 1'b1;
			tok_sent     <= 1'b0;
			spi_start_o  <= 1'b0;
			crc_clear_o  <= 1'b0;
			crc_strobe_o <= 1'b0;
			wr_take_o    <= 1'b0;
			rd_valid_o   <= 1'b0;
			done_o       <= 1'b0;
			err_o        <= 1'b0;
			cs_o         <= 1'b1;
		end else begin
			spi_start_o  <= 1'b0;
			crc_clear_o  <= 1'b0;
			crc_strobe_o <= 1'b0;
			wr_take_o    <= 1'b0;
			rd_valid_o   <= 1'b0;
			done_o       <= 1'b0;
			if (state == FAULT) begin
				err_o <= 1'b1;
				cs_o  <= 1'b1;
			end else if (launch) begin
				spi_start_o  <= 1'b1;
				spi_busy     <= 1'b1;
				crc_strobe_o <= strobe_tx;
				wr_take_o    <= take_tx;
			end else if (state == IDLE) begin
				if (req_valid_i) begin
					state       <= SEND_CMD;
					cnt         <= '0;
					cs_o        <= 1'b0;
					crc_clear_o <= 1'b1;
				end
			end else if (rx_done) begin
				spi_busy <= 1'b0;
				case (state)
					POWER_UP: begin
						if (cnt == CNT_W'(POWER_UP_BYTES - 1)) begin
							state       <= SEND_CMD;
							cnt         <= '0;
							cs_o        <= 1'b0;
							crc_clear_o <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					SEND_CMD: begin
						if (cnt == CNT_W'(CMD_FRAME_BYTES - 1)) begin
							state <= WAIT_R1;
							cnt   <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					WAIT_R1: begin
						// a valid R1 has its top bit clear.
						if (!spi_rx_i[7]) begin
							cnt <= '0;
							if (in_init) begin
								if (spi_rx_i == R1_IDLE) begin
									in_init <= 1'b0;
									cs_o    <= 1'b1;
									state   <= IDLE;
								end else begin
									state <= FAULT;
								end
							end else if (spi_rx_i[6:1] != 6'd0) begin
								state <= FAULT;
							end else if (is_write_i) begin
								state       <= WRITE_DATA;
								tok_sent    <= 1'b0;
								crc_clear_o <= 1'b1;
							end else begin
								state <= WAIT_TOKEN;
							end
						end else if (cnt == CNT_W'(R1_POLL_LIMIT - 1)) begin
							state <= FAULT;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					WAIT_TOKEN: begin
						if (spi_rx_i == START_TOKEN) begin
							state       <= READ_DATA;
							cnt         <= '0;
							crc_clear_o <= 1'b1;
						end else if (spi_rx_i != IDLE_BYTE) begin
							state <= FAULT;
						end else if (cnt == CNT_W'(TOKEN_POLL_LIMIT - 1)) begin
							state <= FAULT;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					READ_DATA: begin
						rd_valid_o   <= 1'b1;
						crc_strobe_o <= 1'b1;
						if (cnt == CNT_W'(BLOCK_BYTES - 1)) begin
							state <= READ_CRC;
							cnt   <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					READ_CRC: begin
						if (cnt == '0) begin
							if (spi_rx_i != crc16_i[15:8])
								state <= FAULT;
							else
								cnt <= cnt + 1'b1;
						end else if (spi_rx_i != crc16_i[7:0]) begin
							state <= FAULT;
						end else begin
							done_o <= 1'b1;
							cs_o   <= 1'b1;
							state  <= IDLE;
						end
					end
					WRITE_DATA: begin
						if (!tok_sent) begin
							tok_sent <= 1'b1;
						end else if (cnt == CNT_W'(BLOCK_BYTES - 1)) begin
							state <= WRITE_CRC;
							cnt   <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					WRITE_CRC: begin
						if (cnt == '0) begin
							cnt <= cnt + 1'b1;
						end else begin
							state <= WAIT_DRESP;
							cnt   <= '0;
						end
					end
					WAIT_DRESP: begin
						if (spi_rx_i != IDLE_BYTE) begin
							cnt   <= '0;
							state <= (spi_rx_i[3:1] == DRESP_ACCEPTED) ? WAIT_BUSY : FAULT;
						end else if (cnt == CNT_W'(R1_POLL_LIMIT - 1)) begin
							state <= FAULT;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					WAIT_BUSY: begin
						// the card holds its output low while busy.
						if (spi_rx_i != 8'h00) begin
							done_o <= 1'b1;
							cs_o   <= 1'b1;
							state  <= IDLE;
						end else if (cnt == CNT_W'(TOKEN_POLL_LIMIT - 1)) begin
							state <= FAULT;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					default: state <= FAULT;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (launch) begin
			spi_tx_o   <= tx_next;
			crc_byte_o <= tx_next;
		end else if (rx_done && state == READ_DATA) begin
			crc_byte_o <= spi_rx_i;
		end
		if (rx_done && state == READ_DATA)
			rd_data_o <= spi_rx_i;
	end

endmodule

// ==== source/sd_spi_phy.sv ====
// ======================================================================
// SD card host PHY in SPI mode; connects the request register, the
// protocol FSM, the byte shifter and the CRC unit.
// ======================================================================
`timescale 1ns/100ps

module sd_spi_phy #(
	parameter int SCLK_DIV         = 4,
	parameter int BLOCK_BYTES      = 512,
	parameter int TOKEN_POLL_LIMIT = 1024
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                req_valid_i,
	input  sd_spi_pkg::sd_req_t req_i,
	input  logic                high_capacity_i,
	output logic                ready_o,
	input  sd_spi_pkg::byte_t   wr_data_i,
	output logic                wr_take_o,
	output sd_spi_pkg::byte_t   rd_data_o,
	output logic                rd_valid_o,
	output logic                done_o,
	output logic                err_o,
	output logic                sclk_o,
	output logic                mosi_o,
	input  logic                miso_i,
	output logic                cs_o
);
	import sd_spi_pkg::*;

	logic        accept;
	logic        go_idle;
	logic [2:0]  frame_idx;
	byte_t       frame_byte;
	logic        is_write;
	logic        spi_start;
	byte_t       spi_tx;
	logic        spi_done;
	byte_t       spi_rx;
	logic        crc_clear;
	byte_t       crc_byte;
	logic        crc_strobe;
	logic [6:0]  crc7;
	logic [15:0] crc16;

	sd_req_regs #(
		.BLOCK_BYTES(BLOCK_BYTES)
	) u_req_regs (
		.clk_i(clk_i), .rst_i(rst_i), .req_valid_i(req_valid_i), .req_i(req_i),
		.accept_i(accept), .high_capacity_i(high_capacity_i), .go_idle_i(go_idle),
		.frame_idx_i(frame_idx), .frame_byte_o(frame_byte), .is_write_o(is_write)
	);

	sd_spi_sequencer #(
		.BLOCK_BYTES(BLOCK_BYTES),
		.TOKEN_POLL_LIMIT(TOKEN_POLL_LIMIT)
	) u_sequencer (
		.clk_i(clk_i), .rst_i(rst_i), .req_valid_i(req_valid_i), .accept_o(accept),
		.ready_o(ready_o), .go_idle_o(go_idle), .frame_idx_o(frame_idx),
		.frame_byte_i(frame_byte), .is_write_i(is_write),
		.spi_start_o(spi_start), .spi_tx_o(spi_tx), .spi_done_i(spi_done), .spi_rx_i(spi_rx),
		.crc_clear_o(crc_clear), .crc_byte_o(crc_byte), .crc_strobe_o(crc_strobe),
		.crc7_i(crc7), .crc16_i(crc16), .wr_data_i(wr_data_i), .wr_take_o(wr_take_o),
		.rd_data_o(rd_data_o), .rd_valid_o(rd_valid_o), .done_o(done_o), .err_o(err_o),
		.cs_o(cs_o)
	);

	spi_byte_master #(
		.SCLK_DIV(SCLK_DIV)
	) u_spi (
		.clk_i(clk_i), .rst_i(rst_i), .start_i(spi_start), .tx_byte_i(spi_tx),
		.rx_byte_o(spi_rx), .done_o(spi_done), .sclk_o(sclk_o), .mosi_o(mosi_o),
		.miso_i(miso_i)
	);

	sd_crc_unit u_crc (
		.clk_i(clk_i), .rst_i(rst_i), .clear_i(crc_clear), .byte_i(crc_byte),
		.strobe_i(crc_strobe), .crc7_o(crc7), .crc16_o(crc16)
	);

endmodule

// ==== sim/sd_card_model.sv ====
// ======================================================================
// SPI-mode SD card responder for the testbench; answers CMD0, CMD17 and
// CMD24 from a byte memory, checks CRCs and can inject faults.
// ======================================================================
`timescale 1ns/100ps

module sd_card_model #(
	parameter int BLOCK_BYTES = 16
) (
	input  logic clk_i,
	input  logic rst_i,
	input  logic sclk_i,
	input  logic mosi_i,
	input  logic cs_i,
	input  logic corrupt_crc_i,
	input  logic reject_wr_i,
	output logic miso_o
);
	import sd_spi_pkg::*;

	typedef enum logic [1:0] {
		C_CMD, C_WTOKEN, C_WDATA
	} card_mode_e;

	logic        sclk_q;
	byte_t       out_sh;
	byte_t       rx_sh;
	int          bit_cnt;
	bit          byte_done;
	byte_t       frame [CMD_FRAME_BYTES];
	int          fidx;
	int          didx;
	card_mode_e  mode;
	byte_t       wdata [BLOCK_BYTES+2];
	byte_t       resp_q [$];
	byte_t       mem [bit [47:0]];
	logic [31:0] wr_arg;

	// flags read by the testbench.
	int          cs_high_clks;
	int          cmd_count;
	logic        crc7_bad;
	logic        crc16_bad;
	logic [5:0]  last_cmd;
	logic [31:0] last_arg;

	assign miso_o = out_sh[7];

	function automatic logic [6:0] crc7_step(input logic [6:0] c, input byte_t b);
		logic fb;
		for (int i = 7; i >= 0; i--) begin
			fb = b[i] ^ c[6];
			c  = {c[5:0], 1'b0};
			if (fb)
				c = c ^ 7'h09;
		end
		return c;
	endfunction

	function automatic logic [15:0] crc16_step(input logic [15:0] c, input byte_t b);
		logic fb;
		for (int i = 7; i >= 0; i--) begin
			fb = b[i] ^ c[15];
			c  = {c[14:0], 1'b0};
			if (fb)
				c = c ^ 16'h1021;
		end
		return c;
	endfunction

	// unwritten locations return a pattern of the whole address.
	function automatic byte_t read_mem(input logic [31:0] arg, input int idx);
		bit [47:0] key;
		key = {arg, 16'(idx)};
		if (mem.exists(key))
			return mem[key];
		return arg[7:0] ^ arg[15:8] ^ arg[23:16] ^ arg[31:24] ^ 8'(idx) ^ 8'h5A;
	endfunction

	task automatic finish_cmd();
		logic [6:0]  c7;
		logic [15:0] c16;
		byte_t       d;
		c7 = '0;
		for (int i = 0; i < 5; i++)
			c7 = crc7_step(c7, frame[i]);
		cmd_count++;
		last_cmd = frame[0][5:0];
		last_arg = {frame[1], frame[2], frame[3], frame[4]};
		if (frame[5] != {c7, 1'b1})
			crc7_bad = 1'b1;
		resp_q.push_back(IDLE_BYTE);
		case (last_cmd)
			6'd0: resp_q.push_back(R1_IDLE);
			6'd17: begin
				resp_q.push_back(8'h00);
				resp_q.push_back(IDLE_BYTE);
				resp_q.push_back(START_TOKEN);
				c16 = '0;
				for (int i = 0; i < BLOCK_BYTES; i++) begin
					d   = read_mem(last_arg, i);
					c16 = crc16_step(c16, d);
					resp_q.push_back(d);
				end
				resp_q.push_back(c16[15:8]);
				resp_q.push_back(c16[7:0] ^ (corrupt_crc_i ? 8'h01 : 8'h00));
			end
			6'd24: begin
				resp_q.push_back(8'h00);
				wr_arg = last_arg;
				mode   = C_WTOKEN;
			end
			default: resp_q.push_back(8'h04);
		endcase
	endtask

	task automatic finish_write();
		logic [15:0] c16;
		c16 = '0;
		for (int i = 0; i < BLOCK_BYTES; i++)
			c16 = crc16_step(c16, wdata[i]);
		if ({wdata[BLOCK_BYTES], wdata[BLOCK_BYTES+1]} != c16)
			crc16_bad = 1'b1;
		if (reject_wr_i || {wdata[BLOCK_BYTES], wdata[BLOCK_BYTES+1]} != c16) begin
			resp_q.push_back(8'h0D);
		end else begin
			for (int i = 0; i < BLOCK_BYTES; i++)
				mem[{wr_arg, 16'(i)}] = wdata[i];
			resp_q.push_back(8'h05);
		end
		// busy for two bytes.
		resp_q.push_back(8'h00);
		resp_q.push_back(8'h00);
		mode = C_CMD;
	endtask

	task automatic handle_byte(input byte_t b);
		case (mode)
			C_CMD: begin
				if (fidx != 0 || b[7:6] == 2'b01) begin
					frame[fidx] = b;
					fidx++;
					if (fidx == CMD_FRAME_BYTES) begin
						fidx = 0;
						finish_cmd();
					end
				end
			end
			C_WTOKEN: begin
				if (b == START_TOKEN) begin
					mode = C_WDATA;
					didx = 0;
				end
			end
			default: begin
				wdata[didx] = b;
				didx++;
				if (didx == BLOCK_BYTES + 2)
					finish_write();
			end
		endcase
	endtask

	// SPI edges are found by sampling sclk with the system clock.
	always @(posedge clk_i) begin
		if (rst_i) begin
			sclk_q       <= 1'b0;
			out_sh       <= IDLE_BYTE;
			bit_cnt      = 0;
			byte_done    = 0;
			fidx         = 0;
			mode         = C_CMD;
			resp_q.delete();
			cs_high_clks = 0;
			cmd_count    = 0;
			crc7_bad     = 1'b0;
			crc16_bad    = 1'b0;
			last_cmd     = '1;
			last_arg     = '0;
		end else begin
			sclk_q <= sclk_i;
			if (cs_i) begin
				bit_cnt   = 0;
				byte_done = 0;
				fidx      = 0;
				mode      = C_CMD;
				resp_q.delete();
				out_sh <= IDLE_BYTE;
				if (sclk_i && !sclk_q)
					cs_high_clks++;
			end else if (sclk_i && !sclk_q) begin
				rx_sh = {rx_sh[6:0], mosi_i};
				bit_cnt++;
				if (bit_cnt == 8) begin
					bit_cnt   = 0;
					byte_done = 1;
					handle_byte(rx_sh);
				end
			end else if (!sclk_i && sclk_q) begin
				if (byte_done) begin
					byte_done = 0;
					out_sh <= (resp_q.size() != 0) ? resp_q.pop_front() : IDLE_BYTE;
				end else begin
					out_sh <= {out_sh[6:0], 1'b1};
				end
			end
		end
	end

endmodule

// ==== sim/sd_spi_phy_asserts.sv ====
// ======================================================================
// Concurrent checks on the PHY ports, bound into every sd_spi_phy.
// ======================================================================
`timescale 1ns/100ps

module sd_spi_phy_asserts (
	input logic clk_i,
	input logic rst_i,
	input logic req_valid_i,
	input logic ready_o,
	input logic done_o,
	input logic err_o,
	input logic rd_valid_o,
	input logic wr_take_o,
	input logic cs_o
);

	a_done_err: assert property (@(posedge clk_i) disable iff (rst_i) !(done_o && err_o))
		else $error("done_o and err_o high together");

	a_rd_cs: assert property (@(posedge clk_i) disable iff (rst_i) rd_valid_o |-> !cs_o)
		else $error("rd_valid_o while cs_o high");

	a_wr_cs: assert property (@(posedge clk_i) disable iff (rst_i) wr_take_o |-> !cs_o)
		else $error("wr_take_o while cs_o high");

	a_ready_drop: assert property (@(posedge clk_i) disable iff (rst_i)
		(ready_o && req_valid_i) |=> !ready_o)
		else $error("ready_o still high after an accepted request");

endmodule

bind sd_spi_phy sd_spi_phy_asserts u_asserts (.*);

// ==== sim/tb_sd_spi_phy.sv ====
// ======================================================================
// Testbench of the SD SPI PHY; LFSR stimulus against a card model and a
// block memory model, run with the file list in the project root.
// ======================================================================
`timescale 1ns/100ps

module tb_sd_spi_phy;
	import sd_spi_pkg::*;

	localparam int SCLK_DIV    = 2;
	localparam int BLOCK_BYTES = 16;
	localparam int N_TESTS     = 6;
	localparam int REQ_CYCLES  = (BLOCK_BYTES + 40) * 16 * SCLK_DIV * 4;
	localparam int WATCHDOG_NS = N_TESTS * REQ_CYCLES * 10;

	logic    clk_i;
	logic    rst_i;
	logic    req_valid_i;
	sd_req_t req_i;
	logic    high_capacity_i;
	logic    ready_o;
	byte_t   wr_data_i;
	logic    wr_take_o;
	byte_t   rd_data_o;
	logic    rd_valid_o;
	logic    done_o;
	logic    err_o;
	logic    sclk;
	logic    mosi;
	logic    miso;
	logic    cs;
	logic    corrupt_crc;
	logic    reject_wr;

	logic [15:0] lfsr_q;
	byte_t       wbuf [BLOCK_BYTES];
	byte_t       rbuf [BLOCK_BYTES];
	byte_t       exp_mem [bit [47:0]];
	int          rcount;
	bit          saw_done;
	bit          saw_err;
	int          errors;
	int          tests_failed;
	int          err_mark;

	sd_spi_phy #(
		.SCLK_DIV(SCLK_DIV),
		.BLOCK_BYTES(BLOCK_BYTES),
		.TOKEN_POLL_LIMIT(64)
	) uut (
		.clk_i(clk_i), .rst_i(rst_i), .req_valid_i(req_valid_i), .req_i(req_i),
		.high_capacity_i(high_capacity_i), .ready_o(ready_o), .wr_data_i(wr_data_i),
		.wr_take_o(wr_take_o), .rd_data_o(rd_data_o), .rd_valid_o(rd_valid_o),
		.done_o(done_o), .err_o(err_o), .sclk_o(sclk), .mosi_o(mosi), .miso_i(miso),
		.cs_o(cs)
	);

	sd_card_model #(
		.BLOCK_BYTES(BLOCK_BYTES)
	) u_card (
		.clk_i(clk_i), .rst_i(rst_i), .sclk_i(sclk), .mosi_i(mosi), .cs_i(cs),
		.corrupt_crc_i(corrupt_crc), .reject_wr_i(reject_wr), .miso_o(miso)
	);

	always #5 clk_i = ~clk_i;

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	// taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		repeat (n) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond)
		else begin
			$display("Error at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_mark);
			tests_failed++;
		end
		err_mark = errors;
	endtask

	task automatic wait_ready(output bit ok);
		int n;
		ok = 0;
		n  = 0;
		while (!ok && n < REQ_CYCLES) begin
			@(posedge clk_i);
			ok = ready_o;
			n++;
		end
		#1;
	endtask

	task automatic reset_powerup(output bit ok);
		@(posedge clk_i);
		#1 rst_i = 1'b1;
		repeat (5) @(posedge clk_i);
		#1 rst_i = 1'b0;
		wait_ready(ok);
		check_true(ok, "ready_o did not rise after power-up");
	endtask

	task automatic fill_wbuf();
		logic [31:0] v;
		for (int i = 0; i < BLOCK_BYTES; i++) begin
			draw(8, v);
			wbuf[i] = v[7:0];
		end
	endtask

	// one request; optionally strobes a second one while the PHY is busy.
	task automatic run_req(input sd_op_e op, input logic [31:0] addr, input logic hc,
	                       input bit extra_strobe);
		bit ok;
		bit take;
		int widx;
		int n;
		wait_ready(ok);
		check_true(ok, "ready_o low before a request");
		widx     = 0;
		rcount   = 0;
		saw_done = 0;
		saw_err  = 0;
		req_valid_i     = 1'b1;
		req_i.op        = op;
		req_i.addr      = addr;
		high_capacity_i = hc;
		wr_data_i       = wbuf[0];
		n = 0;
		while (!(saw_done || saw_err) && n < REQ_CYCLES) begin
			@(posedge clk_i);
			take = wr_take_o;
			if (rd_valid_o) begin
				if (rcount < BLOCK_BYTES)
					rbuf[rcount] = rd_data_o;
				rcount++;
			end
			if (done_o)
				saw_done = 1;
			if (err_o)
				saw_err = 1;
			#1;
			if (take) begin
				widx++;
				if (widx < BLOCK_BYTES)
					wr_data_i = wbuf[widx];
			end
			req_valid_i = extra_strobe && (n == 20);
			if (req_valid_i)
				req_i.addr = ~addr;
			n++;
		end
		req_valid_i = 1'b0;
		check_true(saw_done || saw_err, "request did not end with done_o or err_o");
	endtask

	function automatic logic [31:0] card_arg(input logic [31:0] addr, input logic hc);
		return hc ? addr : addr * BLOCK_BYTES;
	endfunction

	task automatic write_read(input logic [31:0] addr, input logic hc);
		logic [31:0] arg;
		arg = card_arg(addr, hc);
		fill_wbuf();
		run_req(OP_WRITE, addr, hc, 0);
		check_true(saw_done && !saw_err, "write did not end with done_o");
		if (saw_done)
			for (int i = 0; i < BLOCK_BYTES; i++)
				exp_mem[{arg, 16'(i)}] = wbuf[i];
		run_req(OP_READ, addr, hc, 0);
		check_true(saw_done && !saw_err, "read did not end with done_o");
		check_eq("read byte count", rcount, BLOCK_BYTES);
		for (int i = 0; i < BLOCK_BYTES; i++)
			if (exp_mem.exists({arg, 16'(i)}))
				check_eq($sformatf("rd_data_o[%0d]", i), rbuf[i], exp_mem[{arg, 16'(i)}]);
			else
				check_true(0, "read block was never written");
		check_true(!u_card.crc16_bad, "card saw a bad CRC16");
	endtask

	initial begin
		bit          ok;
		logic [31:0] addr;
		logic [31:0] v;
		int          count0;
		clk_i           = 1'b0;
		rst_i           = 1'b1;
		req_valid_i     = 1'b0;
		req_i           = '0;
		high_capacity_i = 1'b1;
		wr_data_i       = '0;
		corrupt_crc     = 1'b0;
		reject_wr       = 1'b0;
		lfsr_q          = 16'd42799;
		errors          = 0;
		tests_failed    = 0;
		err_mark        = 0;

		reset_powerup(ok);
		check_true(!err_o, "err_o high after power-up");
		check_true(u_card.cs_high_clks >= 80, "fewer than 80 clocks with cs_o high");
		check_eq("CMD0 index", u_card.last_cmd, 0);
		check_eq("CMD0 argument", u_card.last_arg, 0);
		check_true(!u_card.crc7_bad, "CMD0 CRC7 invalid");
		end_test("1 power-up");

		draw(32, addr);
		write_read(addr, 1'b1);
		end_test("2 write/read");

		draw(32, addr);
		run_req(OP_READ, addr, 1'b1, 0);
		check_eq("card argument hc", u_card.last_arg, card_arg(addr, 1'b1));
		draw(32, addr);
		run_req(OP_READ, addr, 1'b0, 0);
		check_eq("card argument sc", u_card.last_arg, card_arg(addr, 1'b0));
		check_eq("card command", u_card.last_cmd, 17);
		check_true(!u_card.crc7_bad, "frame CRC7 invalid");
		end_test("3 addressing");

		corrupt_crc = 1'b1;
		draw(32, addr);
		run_req(OP_READ, addr, 1'b1, 0);
		corrupt_crc = 1'b0;
		check_true(saw_err && !saw_done, "corrupted CRC16 not flagged");
		repeat (100) @(posedge clk_i);
		#1 check_true(err_o, "err_o did not stay high");
		end_test("4 read CRC fault");

		reset_powerup(ok);
		reject_wr = 1'b1;
		fill_wbuf();
		draw(32, addr);
		run_req(OP_WRITE, addr, 1'b1, 0);
		reject_wr = 1'b0;
		check_true(saw_err && !saw_done, "rejected write not flagged");
		reset_powerup(ok);
		check_true(!err_o, "err_o high after new reset");
		draw(32, addr);
		write_read(addr, 1'b0);
		end_test("5 write rejection");

		draw(1, v);
		draw(32, addr);
		count0 = u_card.cmd_count;
		run_req(OP_READ, addr, v[0], 1);
		check_true(saw_done, "read with extra strobe did not finish");
		// long enough for a whole command frame to reach the card.
		repeat (CMD_FRAME_BYTES * 16 * SCLK_DIV * 2) @(posedge clk_i);
		#1;
		check_eq("card command count", u_card.cmd_count, count0 + 1);
		check_eq("card argument", u_card.last_arg, card_arg(addr, v[0]));
		check_true(ready_o, "PHY not ready after ignored strobe");
		end_test("6 ignored request");

		$display("%0d tests, %0d failed, %0d errors", N_TESTS, tests_failed, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sd_spi_phy.f ====
source/sd_spi_pkg.sv
source/spi_byte_master.sv
source/sd_crc_unit.sv
source/sd_req_regs.sv
source/sd_spi_sequencer.sv
source/sd_spi_phy.sv
sim/sd_card_model.sv
sim/sd_spi_phy_asserts.sv
sim/tb_sd_spi_phy.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; fails unless the pass message appears.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sd_spi_phy \
	-f sd_spi_phy.f -o tb_sim || exit 1
./obj_dir/tb_sim | tee /dev/stderr | grep -q "TB PASSED" && echo "simulation passed" || exit 1
